// ==== include/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path and address width
`define WORDSZ 64

// one RV instruction
`define INSTSZ 32

// register index width, 32 architectural registers
`define REGSZ 5

// instruction FIFO entries
// keep this a power of two and at least 4 so room can hold two pushes
`define IBUF_DEPTH 8

`endif

// ==== src/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

  // major opcodes from inst[6:0]
  typedef enum logic [6:0] {
    OP_IMM   = 7'b0010011,  // addi andi ori xori slli srli
    OP_REG   = 7'b0110011,  // add sub and or xor sll srl
    OP_LUI   = 7'b0110111,
    OP_OTHER = 7'b1111111   // anything we don't execute
  } opcode_e;

  // alu operation picked by decode
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL,
    PASS,  // result is operand b, used by lui
    NOP
  } alu_op_e;

  typedef enum logic [1:0] {
    F_IDLE,     // waiting for room in the buffer
    F_REQ,      // reqcyc up, waiting for reqack
    F_WAIT,     // waiting for respcyc, then low push
    F_PUSH_HI   // push upper half and step the address
  } fetch_state_e;

  // one decoded op handed from decode to execute
  typedef struct packed {
    alu_op_e             op;
    logic [`REGSZ-1:0]   rd;
    logic [`REGSZ-1:0]   rs1;
    logic [`REGSZ-1:0]   rs2;
    logic                imm_sel;  // operand b comes from imm
    logic [`WORDSZ-1:0]  a;        // rs1 value as read in decode
    logic [`WORDSZ-1:0]  b;        // rs2 value as read in decode
    logic [`WORDSZ-1:0]  imm;      // already sign extended
    logic                wr;       // writes a register other than x0
    logic [`WORDSZ-1:0]  pc;
  } dec_op_t;

endpackage

// ==== src/inst_if.sv ====
`include "core_macros.svh"

// fetch -> buffer
interface inst_push_if;
  logic                push;  // one-cycle strobe per instruction
  logic [`INSTSZ-1:0]  inst;
  logic [`WORDSZ-1:0]  pc;
  logic                room;  // at least two free entries

  modport producer (
    output push, inst, pc,
    input  room
  );

  modport buffer (
    input  push, inst, pc,
    output room
  );
endinterface

// buffer -> decode
interface inst_pop_if;
  logic                avail;  // fifo not empty
  logic [`INSTSZ-1:0]  inst;   // head entry
  logic [`WORDSZ-1:0]  pc;
  logic                pop;

  modport buffer (
    output avail, inst, pc,
    input  pop
  );

  modport consumer (
    input  avail, inst, pc,
    output pop
  );
endinterface

// ==== src/bus_fetch.sv ====
`include "core_macros.svh"

module bus_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic [`WORDSZ-1:0]  entry,
  output logic                bus_reqcyc,
  output logic [`WORDSZ-1:0]  bus_req,
  input  logic                bus_reqack,
  input  logic                bus_respcyc,
  input  logic [`WORDSZ-1:0]  bus_resp,
  output logic                bus_respack,
  inst_push_if.producer       ip
);

  core_pkg::fetch_state_e state;
  logic [`WORDSZ-1:0] addr;      // word aligned fetch address, entry assumed 8 byte aligned
  logic [`WORDSZ-1:0] word;      // last response, two instructions
  logic               lo_pend;   // cycle after respcyc, ack and low push
  logic               resp_take;

  // only one request in flight, so any respcyc belongs to us
  assign resp_take = bus_respcyc && !lo_pend &&
                     (state == core_pkg::F_REQ || state == core_pkg::F_WAIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= core_pkg::F_IDLE;
      addr    <= entry;
      lo_pend <= 1'b0;
    end else begin
      lo_pend <= resp_take;
      case (state)
        core_pkg::F_IDLE: begin
          if (ip.room) state <= core_pkg::F_REQ;  // both halves are sure to fit
        end
        core_pkg::F_REQ: begin
          if (bus_reqack) state <= core_pkg::F_WAIT;
        end
        core_pkg::F_WAIT: begin
          if (lo_pend) state <= core_pkg::F_PUSH_HI;  // low half goes out this cycle
        end
        core_pkg::F_PUSH_HI: begin
          addr  <= addr + `WORDSZ'(8);  // next word
          state <= core_pkg::F_IDLE;
        end
        default: state <= core_pkg::F_IDLE;
      endcase
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (resp_take) word <= bus_resp;
  end

  assign bus_reqcyc  = (state == core_pkg::F_REQ);  // held until reqack
  assign bus_req     = addr;
  assign bus_respack = lo_pend;

  // low instruction at addr, high one at addr+4
  assign ip.push = lo_pend || (state == core_pkg::F_PUSH_HI);
  assign ip.inst = (state == core_pkg::F_PUSH_HI) ? word[`WORDSZ-1:`INSTSZ]
                                                  : word[`INSTSZ-1:0];
  assign ip.pc   = (state == core_pkg::F_PUSH_HI) ? addr + `WORDSZ'(4) : addr;

endmodule

// ==== src/inst_buffer.sv ====
`include "core_macros.svh"

module inst_buffer (
  input  logic        clk,
  input  logic        reset,
  inst_push_if.buffer ip,
  inst_pop_if.buffer  op
);

  localparam int AW = $clog2(`IBUF_DEPTH);

  logic [`INSTSZ-1:0] inst_mem [`IBUF_DEPTH];
  logic [`WORDSZ-1:0] pc_mem   [`IBUF_DEPTH];
  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [AW:0]        count;  // 0 .. IBUF_DEPTH

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (ip.push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (op.pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({ip.push, op.pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or push and pop together
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (ip.push) begin
      inst_mem[wr_ptr] <= ip.inst;
      pc_mem[wr_ptr]   <= ip.pc;
    end
  end

  assign ip.room  = (count <= (AW+1)'(`IBUF_DEPTH - 2));  // fetch pushes in pairs
  assign op.avail = (count != '0);
  assign op.inst  = inst_mem[rd_ptr];  // head, visible the cycle after its push
  assign op.pc    = pc_mem[rd_ptr];

endmodule

// ==== src/reg_decode.sv ====
`include "core_macros.svh"

module reg_decode (
  input  logic                clk,
  input  logic                reset,
  input  logic [`WORDSZ-1:0]  stackptr,
  inst_pop_if.consumer        op,
  input  logic                wb_valid,
  input  logic [`REGSZ-1:0]   wb_rd,
  input  logic [`WORDSZ-1:0]  wb_data,
  output logic                dec_valid,
  output core_pkg::dec_op_t   dec
);

  logic [`WORDSZ-1:0] regs [32];
  logic [`INSTSZ-1:0] inst;
  logic [`REGSZ-1:0]  rs1, rs2;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [`WORDSZ-1:0] rd_a, rd_b;
  core_pkg::opcode_e  opc;
  core_pkg::dec_op_t  d;

  assign op.pop = op.avail;  // consumer never stalls
  assign inst   = op.inst;
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // x0 is zero, same-cycle writeback wins over the array
  assign rd_a = (rs1 == '0) ? '0 : (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rd_b = (rs2 == '0) ? '0 : (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];

  always_comb begin
    case (inst[6:0])
      core_pkg::OP_IMM, core_pkg::OP_REG, core_pkg::OP_LUI: opc = core_pkg::opcode_e'(inst[6:0]);
      default: opc = core_pkg::OP_OTHER;
    endcase
  end

  always_comb begin
    d         = '0;
    d.op      = core_pkg::NOP;
    d.rd      = inst[11:7];
    d.rs1     = rs1;
    d.rs2     = rs2;
    d.imm_sel = 1'b1;
    d.imm     = {{(`WORDSZ-12){inst[31]}}, inst[31:20]};  // i-type
    d.a       = rd_a;
    d.b       = rd_b;
    d.pc      = op.pc;
    case (opc)
      core_pkg::OP_IMM: begin
        case (funct3)
          3'b000: d.op = core_pkg::ADD;
          3'b100: d.op = core_pkg::XOR;
          3'b110: d.op = core_pkg::OR;
          3'b111: d.op = core_pkg::AND;
          3'b001: if (inst[31:26] == 6'b0) d.op = core_pkg::SLL;  // 6 bit shamt
          3'b101: if (inst[31:26] == 6'b0) d.op = core_pkg::SRL;  // srai stays nop
          default: d.op = core_pkg::NOP;
        endcase
      end
      core_pkg::OP_REG: begin
        d.imm_sel = 1'b0;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  d.op = core_pkg::ADD;
            3'b001:  d.op = core_pkg::SLL;
            3'b100:  d.op = core_pkg::XOR;
            3'b101:  d.op = core_pkg::SRL;
            3'b110:  d.op = core_pkg::OR;
            3'b111:  d.op = core_pkg::AND;
            default: d.op = core_pkg::NOP;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          d.op = core_pkg::SUB;
        end
      end
      core_pkg::OP_LUI: begin
        d.op  = core_pkg::PASS;
        d.imm = {{(`WORDSZ-32){inst[31]}}, inst[31:12], 12'b0};
      end
      default: d.op = core_pkg::NOP;  // loads, stores, branches ...
    endcase
    d.wr = (d.op != core_pkg::NOP) && (d.rd != '0);
    if (!d.wr) d.op = core_pkg::NOP;  // rd of x0 retires as a no-op too
  end

  // register file, x2 starts at the stack pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= (i == 2) ? stackptr : '0;
    end else if (wb_valid && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) dec_valid <= 1'b0;
    else       dec_valid <= op.avail;
  end

  always_ff @(posedge clk) begin
    if (op.avail) dec <= d;
  end

endmodule

// ==== src/alu_exec.sv ====
`include "core_macros.svh"

module alu_exec (
  input  logic                clk,
  input  logic                reset,
  input  logic                dec_valid,
  input  core_pkg::dec_op_t   dec,
  output logic                wb_valid,
  output logic [`REGSZ-1:0]   wb_rd,
  output logic [`WORDSZ-1:0]  wb_data,
  output logic [`WORDSZ-1:0]  wb_pc
);

  logic               fwd_a, fwd_b;
  logic [`WORDSZ-1:0] a, b;
  logic [`WORDSZ-1:0] res;

  // previous result is still only in wb_data, decode read a stale value
  assign fwd_a = wb_valid && (wb_rd == dec.rs1);
  assign fwd_b = wb_valid && (wb_rd == dec.rs2) && !dec.imm_sel;

  assign a = fwd_a ? wb_data : dec.a;
  assign b = dec.imm_sel ? dec.imm : (fwd_b ? wb_data : dec.b);

  always_comb begin
    case (dec.op)
      core_pkg::ADD:  res = a + b;
      core_pkg::SUB:  res = a - b;
      core_pkg::AND:  res = a & b;
      core_pkg::OR:   res = a | b;
      core_pkg::XOR:  res = a ^ b;
      core_pkg::SLL:  res = a << b[5:0];  // rv64 shift amount
      core_pkg::SRL:  res = a >> b[5:0];
      core_pkg::PASS: res = b;            // lui
      default:        res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) wb_valid <= 1'b0;
    else       wb_valid <= dec_valid && dec.wr;
  end

  // result register, also the forwarding source
  always_ff @(posedge clk) begin
    if (dec_valid && dec.wr) begin
      wb_rd   <= dec.rd;
      wb_data <= res;
      wb_pc   <= dec.pc;
    end
  end

endmodule

// ==== src/top.sv ====
`include "core_macros.svh"

module top (
  input  logic                clk,
  input  logic                reset,

  input  logic [`WORDSZ-1:0]  entry,     // first fetch address
  input  logic [`WORDSZ-1:0]  stackptr,  // reset value of x2

  // instruction bus
  output logic                bus_reqcyc,
  output logic                bus_respack,
  output logic [`WORDSZ-1:0]  bus_req,
  input  logic                bus_reqack,
  input  logic                bus_respcyc,
  input  logic [`WORDSZ-1:0]  bus_resp,

  // retired results
  output logic                wb_valid,
  output logic [`REGSZ-1:0]   wb_rd,
  output logic [`WORDSZ-1:0]  wb_data,
  output logic [`WORDSZ-1:0]  wb_pc
);

  logic              dec_valid;
  core_pkg::dec_op_t dec;

  inst_push_if ipush ();
  inst_pop_if  ipop ();

  bus_fetch fetch (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .bus_reqcyc  (bus_reqcyc),
    .bus_req     (bus_req),
    .bus_reqack  (bus_reqack),
    .bus_respcyc (bus_respcyc),
    .bus_resp    (bus_resp),
    .bus_respack (bus_respack),
    .ip          (ipush.producer)
  );

  inst_buffer ibuf (
    .clk   (clk),
    .reset (reset),
    .ip    (ipush.buffer),
    .op    (ipop.buffer)
  );

  // writeback loops back here for the register file
  reg_decode decode (
    .clk       (clk),
    .reset     (reset),
    .stackptr  (stackptr),
    .op        (ipop.consumer),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  alu_exec exec (
    .clk       (clk),
    .reset     (reset),
    .dec_valid (dec_valid),
    .dec       (dec),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .wb_pc     (wb_pc)
  );

endmodule

// ==== tests/bus_mem_model.sv ====
`include "core_macros.svh"

// instruction memory behind the split request/response bus
module bus_mem_model #(
  parameter int          NWORDS = 128,    // program size in 64-bit words
  parameter logic [31:0] SEED   = 32'h1
) (
  input  logic                clk,
  input  logic [`WORDSZ-1:0]  base,       // byte address of words[0]
  input  logic                bus_reqcyc,
  input  logic [`WORDSZ-1:0]  bus_req,
  output logic                bus_reqack,
  output logic                bus_respcyc,
  output logic [`WORDSZ-1:0]  bus_resp,
  input  logic                bus_respack
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`WORDSZ-1:0] words [NWORDS];
  logic [31:0]        rng = SEED;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // 0..7 cycles for the first half of the program, 0..1 for the rest
  function automatic int pick_delay(input bit slow);
    rng = xorshift(rng);
    return slow ? int'(rng[2:0]) : int'(rng[0]);
  endfunction

  // each step lands 2 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic serve();
    logic [`WORDSZ-1:0] addr;
    logic [`WORDSZ-1:0] offs;
    bit                 slow;
    addr = bus_req;
    offs = (addr - base) >> 3;  // word index
    slow = (offs < NWORDS / 2);
    wait_cycles(pick_delay(slow));
    bus_reqack = 1'b1;
    wait_cycles(1);
    bus_reqack = 1'b0;
    wait_cycles(pick_delay(slow));
    // past the program both halves get opcode 7f, the rest comes from the address
    bus_resp    = (offs < NWORDS) ? words[offs]
                                  : ({addr[31:0], addr[63:32]} | 64'h0000007f_0000007f);
    bus_respcyc = 1'b1;
    wait_cycles(1);
    bus_respcyc = 1'b0;
    while (!bus_respack) wait_cycles(1);
  endtask

  initial begin
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    forever begin
      wait_cycles(1);
      if (bus_reqcyc) serve();  // one transaction at a time
    end
  end

  // even instruction index goes to the low half of its word
  task automatic load_inst(input int idx, input logic [`INSTSZ-1:0] inst);
    if (idx[0]) words[idx / 2][63:32] = inst;
    else        words[idx / 2][31:0]  = inst;
  endtask

endmodule

// ==== tests/tb_top.sv ====
`include "core_macros.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NINST   = 256;
  localparam int NWORDS  = NINST / 2;
  localparam int TIMEOUT = NWORDS * (16 + 4) + 200;  // cycles
  localparam logic [`WORDSZ-1:0] ENTRY = 64'h0000_0000_8000_1000;
  localparam logic [`WORDSZ-1:0] STACK = 64'h0000_0000_8fff_fff0;

  logic               clk;
  logic               reset;
  logic [`WORDSZ-1:0] entry;
  logic [`WORDSZ-1:0] stackptr;
  logic               bus_reqcyc;
  logic               bus_respack;
  logic [`WORDSZ-1:0] bus_req;
  logic               bus_reqack;
  logic               bus_respcyc;
  logic [`WORDSZ-1:0] bus_resp;
  logic               wb_valid;
  logic [`REGSZ-1:0]  wb_rd;
  logic [`WORDSZ-1:0] wb_data;
  logic [`WORDSZ-1:0] wb_pc;

  logic [`INSTSZ-1:0] prog [NINST];
  logic [`WORDSZ-1:0] model_regs [32];
  logic [31:0]        rng = 32'h50284130;
  logic [`WORDSZ-1:0] exp_req;             // next expected bus address
  logic               reqcyc_q = 1'b0;
  logic               respcyc_q = 1'b0;
  int                 n_writes;            // writebacks the program must produce
  int                 n_seen;
  int                 next_idx;            // model pc as an instruction index
  int                 cycles;

  top dut (.*);

  bus_mem_model #(.NWORDS(NWORDS), .SEED(32'h50284130)) mem (.base(entry), .*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // registers from x0..x5 only, so hazards show up back to back
  function automatic logic [`INSTSZ-1:0] gen_inst();
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  opc;
    r   = next_rand();
    s   = next_rand();
    rd  = 5'(r[7:0] % 6);
    rs1 = 5'(r[15:8] % 6);
    rs2 = 5'(r[23:16] % 6);
    f3  = r[26:24];
    imm = s[11:0];
    case (r[31:28])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin  // op-imm, some srai mixed in
        if (f3 == 3'b001 || f3 == 3'b101) imm[11:6] = (s[13:12] == 2'b11) ? 6'b010000 : 6'b0;
        return {imm, rs1, f3, rd, 7'b0010011};
      end
      4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10: begin  // op-reg
        if (r[27] && !s[14]) f3 = 3'b000;  // mostly sub
        return {(r[27] ? 7'b0100000 : 7'b0000000), rs2, rs1, f3, rd, 7'b0110011};
      end
      4'd11, 4'd12: return {s[31:12], rd, 7'b0110111};  // lui
      4'd13, 4'd14: begin
        case (s[1:0])
          2'd0:    opc = 7'b0000011;  // load
          2'd1:    opc = 7'b0100011;  // store
          2'd2:    opc = 7'b1100011;  // branch
          default: opc = 7'b0011011;  // op-imm-32
        endcase
        return {s[26:2], opc};
      end
      default: return {imm, 5'd0, 3'b000, rd, 7'b0010011};  // addi from x0
    endcase
  endfunction

  // one instruction on the model register file, rv64 rules for the subset
  function automatic void ref_exec(input logic [`INSTSZ-1:0] inst, output logic wr,
                                   output logic [`REGSZ-1:0] rd, output logic [`WORDSZ-1:0] val);
    logic [`WORDSZ-1:0] a;
    logic [`WORDSZ-1:0] b;
    logic [`WORDSZ-1:0] imm;
    logic [2:0]         f3;
    logic               ok;
    a   = model_regs[inst[19:15]];  // x0 is never written, stays zero
    b   = model_regs[inst[24:20]];
    imm = {{52{inst[31]}}, inst[31:20]};
    f3  = inst[14:12];
    rd  = inst[11:7];
    ok  = 1'b1;
    val = '0;
    case (inst[6:0])
      7'b0010011: begin
        case (f3)
          3'b000:  val = a + imm;
          3'b100:  val = a ^ imm;
          3'b110:  val = a | imm;
          3'b111:  val = a & imm;
          3'b001: begin
            ok  = (inst[31:26] == 6'b0);
            val = a << inst[25:20];
          end
          3'b101: begin
            ok  = (inst[31:26] == 6'b0);  // srai is outside the subset
            val = a >> inst[25:20];
          end
          default: ok = 1'b0;
        endcase
      end
      7'b0110011: begin
        case ({inst[31:25], f3})
          {7'h00, 3'b000}: val = a + b;
          {7'h20, 3'b000}: val = a - b;
          {7'h00, 3'b001}: val = a << b[5:0];
          {7'h00, 3'b100}: val = a ^ b;
          {7'h00, 3'b101}: val = a >> b[5:0];
          {7'h00, 3'b110}: val = a | b;
          {7'h00, 3'b111}: val = a & b;
          default:         ok = 1'b0;
        endcase
      end
      7'b0110111: val = {{32{inst[31]}}, inst[31:12], 12'b0};
      default:    ok = 1'b0;
    endcase
    wr = ok && (rd != '0);
  endfunction

  task automatic init_model();
    for (int i = 0; i < 32; i++) model_regs[i] = (i == 2) ? STACK : '0;
  endtask

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [`WORDSZ-1:0] exp,
                                 input logic [`WORDSZ-1:0] act);
    $display("Fail %s: expected %h, actual %h", name, exp, act);
    abort_run();
  endtask

  initial begin
    logic               wr;
    logic [`REGSZ-1:0]  rd;
    logic [`WORDSZ-1:0] val;
    reset    = 1'b1;
    entry    = ENTRY;
    stackptr = STACK;
    exp_req  = ENTRY;
    for (int i = 0; i < NINST; i++) prog[i] = gen_inst();
    prog[0] = {12'd16, 5'd2, 3'b000, 5'd1, 7'b0010011};       // addi x1, x2, 16
    prog[1] = {7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011};   // add x3, x1, x2
    for (int i = 0; i < NINST; i++) mem.load_inst(i, prog[i]);
    init_model();
    for (int i = 0; i < NINST; i++) begin  // count the writebacks to expect
      ref_exec(prog[i], wr, rd, val);
      if (wr) begin
        model_regs[rd] = val;
        n_writes++;
      end
    end
    init_model();
    repeat (8) @(posedge clk);
    #2 reset = 1'b0;
  end

  // reset levels, request addresses and the respack timing
  always @(negedge clk) begin
    if (cycles > 0) begin  // nothing is sampled before the first rising edge
      if (reset) begin
        assert (!bus_reqcyc && !bus_respack && !wb_valid) else begin
          $display("bus_reqcyc, bus_respack or wb_valid is high during reset");
          abort_run();
        end
      end else begin
        if (bus_reqcyc && !reqcyc_q) begin  // new request
          assert (bus_req == exp_req) else report_mismatch("bus_req", exp_req, bus_req);
          exp_req += 64'd8;
        end
        assert (bus_respack == respcyc_q) else begin
          $display("bus_respack does not follow bus_respcyc by exactly one cycle");
          abort_run();
        end
      end
    end
    reqcyc_q  = bus_reqcyc;
    respcyc_q = bus_respcyc;
  end

  // walk the model over no-ops to the next writing instruction and compare
  always @(negedge clk) begin
    logic               wr;
    logic [`REGSZ-1:0]  rd;
    logic [`WORDSZ-1:0] val;
    logic [`WORDSZ-1:0] pc;
    if (!reset && wb_valid) begin
      wr = 1'b0;
      while (!wr && next_idx < NINST) begin
        ref_exec(prog[next_idx], wr, rd, val);
        pc = ENTRY + `WORDSZ'(4 * next_idx);
        next_idx++;
      end
      assert (wr) else begin
        $display("writeback at pc %h with no writing instruction left in the program", wb_pc);
        abort_run();
      end
      assert (wb_pc == pc) else report_mismatch("wb_pc", pc, wb_pc);
      assert (wb_rd == rd) else report_mismatch("wb_rd", `WORDSZ'(rd), `WORDSZ'(wb_rd));
      assert (wb_data == val) else report_mismatch("wb_data", val, wb_data);
      model_regs[rd] = val;
      n_seen++;
      if (n_seen == n_writes) begin
        $display("TEST PASSED");
        $finish;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("timeout, writeback stream stalled after %0d of %0d results", n_seen, n_writes);
      abort_run();
    end
  end

endmodule

// ==== files.f ====
+incdir+include
src/core_pkg.sv
src/inst_if.sv
src/bus_fetch.sv
src/inst_buffer.sv
src/reg_decode.sv
src/alu_exec.sv
src/top.sv
tests/bus_mem_model.sv
tests/tb_top.sv
